//--- rtl/aib_dfx_pkg.sv
// ==================================================
// Shared widths, register map and monitor codes for
// the die-to-die DFx monitor. Referenced by scoped name
// ==================================================

package aib_dfx_pkg;

  // Debug pins inside one IO and analog view points
  localparam int PINS_PER_IO   = 5;
  localparam int NUM_ANA_VIEWS = 5;

  // Register interface
  typedef logic [1:0]  csr_addr_t;
  typedef logic [15:0] csr_data_t;

  localparam csr_addr_t CSR_CTRL = 2'd0;
  localparam csr_addr_t CSR_DIG  = 2'd1;
  localparam csr_addr_t CSR_ANA  = 2'd2;

  // Control register bit positions
  localparam int CTRL_EN_DIGMON = 0;
  localparam int CTRL_EN_ANAMON = 1;

  // Digital code is {block[15:10], io[9:3], pin[2:0]}
  typedef logic [15:0] dig_code_t;
  typedef logic [6:0]  io_idx_t;
  typedef logic [2:0]  pin_idx_t;

  // Analog view select code
  typedef logic [2:0] ana_code_t;

  // Block field of the digital code
  typedef enum logic [5:0] {
    blk_none   = 6'd0,
    blk_txrx   = 6'd1,
    blk_tx_dll = 6'd2,
    blk_rx_dll = 6'd3,
    blk_dcs    = 6'd4
  } blk_sel_e;

endpackage

//--- rtl/aib_dfx_csr.sv
// ==================================================
// Monitor register block. Single-cycle write strobe,
// combinational read-back, pulse on rejected writes
// ==================================================

`timescale 1ns/1ps

module aib_dfx_csr (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_en,
  input  aib_dfx_pkg::csr_addr_t wr_addr,
  input  aib_dfx_pkg::csr_data_t wr_data,
  input  aib_dfx_pkg::csr_addr_t rd_addr,
  output aib_dfx_pkg::csr_data_t rd_data,
  output logic                   wr_err,
  output logic                   en_digmon,
  output logic                   en_anamon,
  output aib_dfx_pkg::dig_code_t dig_code,
  output aib_dfx_pkg::ana_code_t ana_code
);

  logic wr_ctrl;
  logic wr_dig;
  logic wr_ana;
  logic ctrl_both;
  logic ctrl_reject;

  // ==================================================
  // Write decode
  // ==================================================
  assign wr_ctrl = wr_en && (wr_addr == aib_dfx_pkg::CSR_CTRL);
  assign wr_dig  = wr_en && (wr_addr == aib_dfx_pkg::CSR_DIG);
  assign wr_ana  = wr_en && (wr_addr == aib_dfx_pkg::CSR_ANA);

  // Only one monitor mode may be active at a time
  assign ctrl_both   = wr_data[aib_dfx_pkg::CTRL_EN_DIGMON] &&
                       wr_data[aib_dfx_pkg::CTRL_EN_ANAMON];
  assign ctrl_reject = wr_ctrl && ctrl_both;

  // Control register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_digmon <= 1'b0;
      en_anamon <= 1'b0;
    end else if (wr_ctrl && !ctrl_both) begin
      en_digmon <= wr_data[aib_dfx_pkg::CTRL_EN_DIGMON];
      en_anamon <= wr_data[aib_dfx_pkg::CTRL_EN_ANAMON];
    end
  end

  // Digital and analog code registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dig_code <= '0;
      ana_code <= '0;
    end else begin
      if (wr_dig) begin
        dig_code <= wr_data;
      end
      if (wr_ana) begin
        ana_code <= wr_data[$bits(aib_dfx_pkg::ana_code_t)-1:0];
      end
    end
  end

  // Error pulse, one cycle per rejected control write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_err <= 1'b0;
    end else begin
      wr_err <= ctrl_reject;
    end
  end

  // ==================================================
  // Read-back
  // ==================================================
  always_comb begin
    rd_data = '0;
    case (rd_addr)
      aib_dfx_pkg::CSR_CTRL: begin
        rd_data[aib_dfx_pkg::CTRL_EN_DIGMON] = en_digmon;
        rd_data[aib_dfx_pkg::CTRL_EN_ANAMON] = en_anamon;
      end
      aib_dfx_pkg::CSR_DIG: begin
        rd_data = dig_code;
      end
      aib_dfx_pkg::CSR_ANA: begin
        rd_data[$bits(aib_dfx_pkg::ana_code_t)-1:0] = ana_code;
      end
      // Address 3 is unmapped and reads zero
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // ==================================================
  // Checks
  // ==================================================
  // Decoder relies on the two modes being exclusive
  a_modes_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(en_digmon && en_anamon)
  ) else $error("both monitor modes enabled");

endmodule

//--- rtl/aib_dfx_mon.sv
// ==================================================
// Monitor code decoder. Turns the register codes into
// block enables, per-IO enables and view selects
// ==================================================

`timescale 1ns/1ps

module aib_dfx_mon #(
  parameter int NUM_IO = 104
) (
  input  logic                                 en_digmon,
  input  aib_dfx_pkg::dig_code_t               dig_code,
  input  logic                                 en_anamon,
  input  aib_dfx_pkg::ana_code_t               ana_code,
  output logic [NUM_IO-1:0]                    txrx_dfx_en,
  output logic                                 tx_dll_dfx_en,
  output logic                                 rx_dll_dfx_en,
  output logic                                 dcs_dfx_en,
  output logic [aib_dfx_pkg::PINS_PER_IO-1:0]   txrx_digviewsel,
  output aib_dfx_pkg::ana_code_t               txrx_anaviewsel,
  output logic [aib_dfx_pkg::NUM_ANA_VIEWS-1:0] onehot_anaviewsel
);

  aib_dfx_pkg::dig_code_t dig_gated;
  aib_dfx_pkg::ana_code_t ana_gated;
  aib_dfx_pkg::blk_sel_e  blk_sel;
  aib_dfx_pkg::io_idx_t   io_idx;
  aib_dfx_pkg::pin_idx_t  pin_idx;

  logic txrx_blk;
  logic tx_dll_blk;
  logic rx_dll_blk;
  logic dcs_blk;
  logic txrx_blk_en;
  logic io_in_range;

  // Codes count as zero while their mode is off
  assign dig_gated = en_digmon ? dig_code : '0;
  assign ana_gated = en_anamon ? ana_code : '0;

  // Field split of the digital code
  assign blk_sel = aib_dfx_pkg::blk_sel_e'(dig_gated[15:10]);
  assign io_idx  = dig_gated[9:3];
  assign pin_idx = dig_gated[2:0];

  // ==================================================
  // Block select
  // ==================================================
  always_comb begin
    txrx_blk   = 1'b0;
    tx_dll_blk = 1'b0;
    rx_dll_blk = 1'b0;
    dcs_blk    = 1'b0;
    case (blk_sel)
      aib_dfx_pkg::blk_txrx:   txrx_blk   = 1'b1;
      aib_dfx_pkg::blk_tx_dll: tx_dll_blk = 1'b1;
      aib_dfx_pkg::blk_rx_dll: rx_dll_blk = 1'b1;
      aib_dfx_pkg::blk_dcs:    dcs_blk    = 1'b1;
      // blk_none and unused codes select nothing
      default: begin
        txrx_blk = 1'b0;
      end
    endcase
  end

  // Analog mode opens every block so its view points are live
  assign txrx_blk_en   = en_anamon | txrx_blk;
  assign tx_dll_dfx_en = en_anamon | tx_dll_blk;
  assign rx_dll_dfx_en = en_anamon | rx_dll_blk;
  assign dcs_dfx_en    = en_anamon | dcs_blk;

  // ==================================================
  // IO select
  // ==================================================
  assign io_in_range = int'(io_idx) < NUM_IO;

  always_comb begin
    txrx_dfx_en = '0;
    if (io_in_range) begin
      for (int i = 0; i < NUM_IO; i++) begin
        if (int'(io_idx) == i) begin
          txrx_dfx_en[i] = txrx_blk_en;
        end
      end
    end
  end

  // No pin is picked for codes 5 to 7 or with digital mode off
  always_comb begin
    for (int p = 0; p < aib_dfx_pkg::PINS_PER_IO; p++) begin
      txrx_digviewsel[p] = en_digmon && (int'(pin_idx) == p);
    end
  end

  // ==================================================
  // Analog view select
  // ==================================================
  assign txrx_anaviewsel = ana_gated;

  // Code 0 is idle, view v sits at code v+1
  always_comb begin
    for (int v = 0; v < aib_dfx_pkg::NUM_ANA_VIEWS; v++) begin
      onehot_anaviewsel[v] = (int'(ana_gated) == v + 1);
    end
  end

  // Downstream OR trees assume at most one select per group
  always_comb begin
    a_io_onehot0: assert final ($onehot0(txrx_dfx_en))
      else $error("more than one IO enabled");
    a_dig_view_onehot0: assert final ($onehot0(txrx_digviewsel))
      else $error("digital view select not one-hot");
    a_ana_view_onehot0: assert final ($onehot0(onehot_anaviewsel))
      else $error("analog view select not one-hot");
  end

endmodule

//--- rtl/aib_dfx_obs_mux.sv
// ==================================================
// Observation path. Picks one gated debug bit and
// brings it to the observation pin through two flops
// ==================================================

`timescale 1ns/1ps

module aib_dfx_obs_mux #(
  parameter int NUM_IO = 104
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        en_digmon,
  input  logic [NUM_IO-1:0]                           txrx_dfx_en,
  input  logic [aib_dfx_pkg::PINS_PER_IO-1:0]          txrx_digviewsel,
  input  logic                                        tx_dll_dfx_en,
  input  logic                                        rx_dll_dfx_en,
  input  logic                                        dcs_dfx_en,
  input  logic [NUM_IO*aib_dfx_pkg::PINS_PER_IO-1:0]   io_dbg,
  input  logic                                        tx_dll_dbg,
  input  logic                                        rx_dll_dbg,
  input  logic                                        dcs_dbg,
  output logic                                        dig_obs
);

  logic io_hit;
  logic blk_hit;
  logic obs_sel;
  logic obs_meta;
  logic obs_sync;

  // ==================================================
  // Selection
  // ==================================================
  // Pin index runs fastest inside io_dbg
  always_comb begin
    io_hit = 1'b0;
    for (int i = 0; i < NUM_IO; i++) begin
      io_hit = io_hit | (txrx_dfx_en[i] &
               |(io_dbg[i*aib_dfx_pkg::PINS_PER_IO +: aib_dfx_pkg::PINS_PER_IO] &
                 txrx_digviewsel));
    end
  end

  assign blk_hit = (tx_dll_dbg & tx_dll_dfx_en) |
                   (rx_dll_dbg & rx_dll_dfx_en) |
                   (dcs_dbg    & dcs_dfx_en);

  // Nothing reaches the pin outside digital mode
  assign obs_sel = en_digmon & (io_hit | blk_hit);

  // ==================================================
  // Synchronizer
  // ==================================================
  // Debug sources live in other clock domains
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      obs_meta <= 1'b0;
      obs_sync <= 1'b0;
    end else begin
      obs_meta <= obs_sel;
      obs_sync <= obs_meta;
    end
  end

  assign dig_obs = obs_sync;

  // An X here means a debug source or select is floating
  a_obs_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(dig_obs)
  ) else $error("dig_obs is unknown");

endmodule

//--- rtl/aib_dfx_top.sv
// ==================================================
// DFx monitor top level. Register block, code decoder
// and observation mux, wired together
// ==================================================

`timescale 1ns/1ps

module aib_dfx_top #(
  parameter int NUM_IO = 104
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        wr_en,
  input  aib_dfx_pkg::csr_addr_t                      wr_addr,
  input  aib_dfx_pkg::csr_data_t                      wr_data,
  input  aib_dfx_pkg::csr_addr_t                      rd_addr,
  output aib_dfx_pkg::csr_data_t                      rd_data,
  output logic                                        wr_err,
  input  logic [NUM_IO*aib_dfx_pkg::PINS_PER_IO-1:0]   io_dbg,
  input  logic                                        tx_dll_dbg,
  input  logic                                        rx_dll_dbg,
  input  logic                                        dcs_dbg,
  output logic                                        dig_obs,
  output logic                                        tx_dll_dfx_en,
  output logic                                        rx_dll_dfx_en,
  output logic                                        dcs_dfx_en,
  output aib_dfx_pkg::ana_code_t                      txrx_anaviewsel,
  output logic [aib_dfx_pkg::NUM_ANA_VIEWS-1:0]        onehot_anaviewsel
);

  // Register outputs
  logic                   en_digmon;
  logic                   en_anamon;
  aib_dfx_pkg::dig_code_t dig_code;
  aib_dfx_pkg::ana_code_t ana_code;

  // Decoder to observation mux
  logic [NUM_IO-1:0]                       txrx_dfx_en;
  logic [aib_dfx_pkg::PINS_PER_IO-1:0]      txrx_digviewsel;

  aib_dfx_csr u_csr (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .wr_err    (wr_err),
    .en_digmon (en_digmon),
    .en_anamon (en_anamon),
    .dig_code  (dig_code),
    .ana_code  (ana_code)
  );

  aib_dfx_mon #(
    .NUM_IO (NUM_IO)
  ) u_mon (
    .en_digmon         (en_digmon),
    .dig_code          (dig_code),
    .en_anamon         (en_anamon),
    .ana_code          (ana_code),
    .txrx_dfx_en       (txrx_dfx_en),
    .tx_dll_dfx_en     (tx_dll_dfx_en),
    .rx_dll_dfx_en     (rx_dll_dfx_en),
    .dcs_dfx_en        (dcs_dfx_en),
    .txrx_digviewsel   (txrx_digviewsel),
    .txrx_anaviewsel   (txrx_anaviewsel),
    .onehot_anaviewsel (onehot_anaviewsel)
  );

  aib_dfx_obs_mux #(
    .NUM_IO (NUM_IO)
  ) u_obs_mux (
    .clk             (clk),
    .rst_n           (rst_n),
    .en_digmon       (en_digmon),
    .txrx_dfx_en     (txrx_dfx_en),
    .txrx_digviewsel (txrx_digviewsel),
    .tx_dll_dfx_en   (tx_dll_dfx_en),
    .rx_dll_dfx_en   (rx_dll_dfx_en),
    .dcs_dfx_en      (dcs_dfx_en),
    .io_dbg          (io_dbg),
    .tx_dll_dbg      (tx_dll_dbg),
    .rx_dll_dbg      (rx_dll_dbg),
    .dcs_dbg         (dcs_dbg),
    .dig_obs         (dig_obs)
  );

endmodule

//--- tests/tb_aib_dfx.sv
// ==================================================
// Table-driven testbench for the DFx monitor top level.
// Writes the monitor registers, drives debug sources
// and checks outputs against a reference model
// ==================================================

`timescale 1ns/1ps

module tb_aib_dfx;

  localparam int NUM_IO          = 104;
  localparam int PINS            = aib_dfx_pkg::PINS_PER_IO;
  localparam int DBG_W           = NUM_IO * PINS;
  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_TEST = 20;
  // Reset and exclusive-mode tests run outside the table
  localparam int EXTRA_TESTS     = 4;

  // Debug pattern selectors
  localparam int PAT_ONES    = 1;
  localparam int PAT_TARGET  = 2;
  localparam int PAT_ALL_BUT = 3;
  localparam int PAT_RAND    = 4;

  logic                   clk;
  logic                   rst_n;
  logic                   wr_en;
  aib_dfx_pkg::csr_addr_t wr_addr;
  aib_dfx_pkg::csr_data_t wr_data;
  aib_dfx_pkg::csr_addr_t rd_addr;
  aib_dfx_pkg::csr_data_t rd_data;
  logic                   wr_err;
  logic [DBG_W-1:0]       io_dbg;
  logic                   tx_dll_dbg;
  logic                   rx_dll_dbg;
  logic                   dcs_dbg;
  logic                   dig_obs;
  logic                   tx_dll_dfx_en;
  logic                   rx_dll_dfx_en;
  logic                   dcs_dfx_en;
  aib_dfx_pkg::ana_code_t txrx_anaviewsel;
  logic [4:0]             onehot_anaviewsel;

  // Test table, one entry per index
  string       t_name[$];
  logic [15:0] t_ctrl[$];
  logic [15:0] t_dig[$];
  logic [2:0]  t_ana[$];
  int          t_pat[$];

  logic [31:0] lcg_state;
  logic        tbl_ready;
  int          tests_run;
  int          tests_failed;
  int          test_errs;

  aib_dfx_top #(
    .NUM_IO (NUM_IO)
  ) dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .wr_en             (wr_en),
    .wr_addr           (wr_addr),
    .wr_data           (wr_data),
    .rd_addr           (rd_addr),
    .rd_data           (rd_data),
    .wr_err            (wr_err),
    .io_dbg            (io_dbg),
    .tx_dll_dbg        (tx_dll_dbg),
    .rx_dll_dbg        (rx_dll_dbg),
    .dcs_dbg           (dcs_dbg),
    .dig_obs           (dig_obs),
    .tx_dll_dfx_en     (tx_dll_dfx_en),
    .rx_dll_dfx_en     (rx_dll_dfx_en),
    .dcs_dfx_en        (dcs_dfx_en),
    .txrx_anaviewsel   (txrx_anaviewsel),
    .onehot_anaviewsel (onehot_anaviewsel)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==================================================
  // Helpers
  // ==================================================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [15:0] dig_code_of(input int blk, input int io, input int pin);
    logic [5:0] b;
    logic [6:0] i;
    logic [2:0] p;
    b = 6'(blk);
    i = 7'(io);
    p = 3'(pin);
    return {b, i, p};
  endfunction

  task automatic add_entry(input string name, input logic [15:0] ctrl,
                           input logic [15:0] dig, input logic [2:0] ana, input int pat);
    t_name.push_back(name);
    t_ctrl.push_back(ctrl);
    t_dig.push_back(dig);
    t_ana.push_back(ana);
    t_pat.push_back(pat);
  endtask

  // Reference model of the decode and observation rules
  function automatic void model_outputs(
    input  logic [15:0]      ctrl,
    input  logic [15:0]      dig,
    input  logic [2:0]       ana,
    input  logic [DBG_W-1:0] io_pat,
    input  logic [2:0]       blk_pat,
    output logic             obs,
    output logic [2:0]       blk_en,
    output logic [2:0]       ana_sel,
    output logic [4:0]       onehot
  );
    logic        en_d;
    logic        en_a;
    logic [15:0] dg;
    logic [2:0]  ag;
    logic        io_bit;
    int          blk;
    int          io;
    int          pin;
    en_d = ctrl[0];
    en_a = ctrl[1];
    dg   = en_d ? dig : 16'd0;
    ag   = en_a ? ana : 3'd0;
    blk  = int'(dg[15:10]);
    io   = int'(dg[9:3]);
    pin  = int'(dg[2:0]);
    blk_en[0] = en_a || (blk == 2);
    blk_en[1] = en_a || (blk == 3);
    blk_en[2] = en_a || (blk == 4);
    io_bit = 1'b0;
    if ((en_a || blk == 1) && io < NUM_IO && pin < PINS) begin
      io_bit = io_pat[io * PINS + pin];
    end
    obs     = en_d && (io_bit || |(blk_pat & blk_en));
    ana_sel = ag;
    onehot  = (ag >= 3'd1 && ag <= 3'd5) ? (5'b1 << (ag - 3'd1)) : 5'd0;
  endfunction

  // Called on a rising edge; target bits come from the code fields
  task automatic drive_debug(input logic [15:0] dig, input int pat);
    logic [DBG_W-1:0] io_pat;
    logic [2:0]       blk_pat;
    logic [31:0]      r;
    int               blk;
    int               io;
    int               pin;
    blk = int'(dig[15:10]);
    io  = int'(dig[9:3]);
    pin = int'(dig[2:0]);
    io_pat  = '0;
    blk_pat = '0;
    r       = '0;
    if (pat == PAT_ONES) begin
      io_pat  = '1;
      blk_pat = '1;
    end else if (pat == PAT_RAND) begin
      for (int b = 0; b < DBG_W; b++) begin
        if (b % 16 == 0) begin
          r = lcg_next();
        end
        io_pat[b] = r[16 + b % 16];
      end
      r = lcg_next();
      blk_pat = r[20:18];
    end else if (pat == PAT_TARGET || pat == PAT_ALL_BUT) begin
      if (io < NUM_IO && pin < PINS) begin
        io_pat[io * PINS + pin] = 1'b1;
      end
      if (blk >= 2 && blk <= 4) begin
        blk_pat[blk - 2] = 1'b1;
      end
      if (pat == PAT_ALL_BUT) begin
        io_pat  = ~io_pat;
        blk_pat = ~blk_pat;
      end
    end
    io_dbg     <= io_pat;
    tx_dll_dbg <= blk_pat[0];
    rx_dll_dbg <= blk_pat[1];
    dcs_dbg    <= blk_pat[2];
  endtask

  task automatic write_reg(input aib_dfx_pkg::csr_addr_t addr, input logic [15:0] data);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    @(posedge clk);
    wr_en   <= 1'b0;
  endtask

  task automatic check_val(input string name, input string what,
                           input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("Error: test %s, %s expected 0x%0h, actual 0x%0h", name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, test_errs);
    end else begin
      $display("Test %s passed", name);
    end
  endtask

  // ==================================================
  // Test table
  // ==================================================
  task automatic build_table();
    int io_list[4];
    int io;
    io_list[0] = 0;
    io_list[1] = NUM_IO - 1;
    io_list[2] = int'(lcg_next() >> 16) % NUM_IO;
    io_list[3] = int'(lcg_next() >> 16) % NUM_IO;
    foreach (io_list[k]) begin
      for (int p = 0; p < PINS; p++) begin
        add_entry($sformatf("io%0d_pin%0d_high", io_list[k], p), 16'h0001,
                  dig_code_of(1, io_list[k], p), 3'd0, PAT_TARGET);
        add_entry($sformatf("io%0d_pin%0d_low", io_list[k], p), 16'h0001,
                  dig_code_of(1, io_list[k], p), 3'd0, PAT_ALL_BUT);
      end
    end
    for (int k = 0; k < 3; k++) begin
      io = int'(lcg_next() >> 16) % NUM_IO;
      add_entry($sformatf("io%0d_random_%0d", io, k), 16'h0001,
                dig_code_of(1, io, k + 1), 3'd0, PAT_RAND);
    end
    for (int b = 2; b <= 4; b++) begin
      add_entry($sformatf("block%0d_high", b), 16'h0001, dig_code_of(b, 7, 1), 3'd0,
                PAT_TARGET);
      add_entry($sformatf("block%0d_low", b), 16'h0001, dig_code_of(b, 7, 1), 3'd0,
                PAT_ALL_BUT);
    end
    add_entry("block0_none", 16'h0001, dig_code_of(0, 3, 2), 3'd0, PAT_ONES);
    add_entry("block5_unused", 16'h0001, dig_code_of(5, 3, 2), 3'd0, PAT_ONES);
    add_entry("block63_unused", 16'h0001, dig_code_of(63, 3, 2), 3'd0, PAT_ONES);
    add_entry("io104_out_of_range", 16'h0001, dig_code_of(1, 104, 0), 3'd0, PAT_ONES);
    add_entry("io127_out_of_range", 16'h0001, dig_code_of(1, 127, 4), 3'd0, PAT_ONES);
    add_entry("pin5_unused", 16'h0001, dig_code_of(1, 10, 5), 3'd0, PAT_ONES);
    add_entry("pin7_unused", 16'h0001, dig_code_of(1, 10, 7), 3'd0, PAT_ONES);
    add_entry("digmon_off", 16'h0000, dig_code_of(1, 10, 2), 3'd5, PAT_ONES);
    for (int c = 0; c < 8; c++) begin
      add_entry($sformatf("analog_code%0d", c), 16'h0002, dig_code_of(1, 5, 2), 3'(c),
                PAT_ONES);
    end
  endtask

  task automatic apply_entry(input int idx);
    logic       exp_obs;
    logic [2:0] exp_blk;
    logic [2:0] exp_ana;
    logic [4:0] exp_oh;
    string      name;
    name      = t_name[idx];
    test_errs = 0;
    @(posedge clk);
    drive_debug(t_dig[idx], t_pat[idx]);
    write_reg(aib_dfx_pkg::CSR_DIG, t_dig[idx]);
    write_reg(aib_dfx_pkg::CSR_ANA, {13'd0, t_ana[idx]});
    write_reg(aib_dfx_pkg::CSR_CTRL, t_ctrl[idx]);
    // A legal control write raises no error pulse
    @(negedge clk);
    check_val(name, "wr_err", 16'd0, 16'(wr_err));
    // Control write captured, observation pin settles two edges later
    repeat (2) @(posedge clk);
    @(negedge clk);
    model_outputs(t_ctrl[idx], t_dig[idx], t_ana[idx], io_dbg,
                  {dcs_dbg, rx_dll_dbg, tx_dll_dbg}, exp_obs, exp_blk, exp_ana, exp_oh);
    check_val(name, "dig_obs", 16'(exp_obs), 16'(dig_obs));
    check_val(name, "block enables", 16'(exp_blk),
              16'({dcs_dfx_en, rx_dll_dfx_en, tx_dll_dfx_en}));
    check_val(name, "txrx_anaviewsel", 16'(exp_ana), 16'(txrx_anaviewsel));
    check_val(name, "onehot_anaviewsel", 16'(exp_oh), 16'(onehot_anaviewsel));
    check_val(name, "ctrl read-back", {14'd0, t_ctrl[idx][1:0]}, rd_data);
    finish_test(name);
  endtask

  task automatic run_reset_test();
    string name;
    name      = "after_reset";
    test_errs = 0;
    @(negedge clk);
    check_val(name, "dig_obs", 16'd0, 16'(dig_obs));
    check_val(name, "block enables", 16'd0,
              16'({dcs_dfx_en, rx_dll_dfx_en, tx_dll_dfx_en}));
    check_val(name, "txrx_anaviewsel", 16'd0, 16'(txrx_anaviewsel));
    check_val(name, "onehot_anaviewsel", 16'd0, 16'(onehot_anaviewsel));
    check_val(name, "wr_err", 16'd0, 16'(wr_err));
    for (int a = 0; a < 4; a++) begin
      @(posedge clk);
      rd_addr <= 2'(a);
      @(negedge clk);
      check_val($sformatf("%s_read%0d", name, a), "rd_data", 16'd0, rd_data);
    end
    @(posedge clk);
    rd_addr <= aib_dfx_pkg::CSR_CTRL;
    finish_test(name);
  endtask

  task automatic run_exclusive_test();
    string name;
    name      = "exclusive_modes";
    test_errs = 0;
    @(posedge clk);
    io_dbg     <= '0;
    tx_dll_dbg <= 1'b1;
    rx_dll_dbg <= 1'b0;
    dcs_dbg    <= 1'b0;
    write_reg(aib_dfx_pkg::CSR_DIG, dig_code_of(2, 0, 0));
    write_reg(aib_dfx_pkg::CSR_CTRL, 16'h0001);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_val(name, "dig_obs before reject", 16'd1, 16'(dig_obs));
    write_reg(aib_dfx_pkg::CSR_CTRL, 16'h0003);
    @(negedge clk);
    check_val(name, "wr_err on reject", 16'd1, 16'(wr_err));
    check_val(name, "ctrl after reject", 16'h0001, rd_data);
    @(negedge clk);
    check_val(name, "wr_err one cycle", 16'd0, 16'(wr_err));
    // Unmapped address takes no write and raises no error
    write_reg(2'd3, 16'hffff);
    @(negedge clk);
    check_val(name, "wr_err on address 3", 16'd0, 16'(wr_err));
    check_val(name, "ctrl after address 3", 16'h0001, rd_data);
    @(posedge clk);
    rd_addr <= 2'd3;
    @(negedge clk);
    check_val(name, "address 3 read-back", 16'd0, rd_data);
    @(posedge clk);
    rd_addr <= aib_dfx_pkg::CSR_CTRL;
    write_reg(aib_dfx_pkg::CSR_CTRL, 16'h0000);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_val(name, "dig_obs after clear", 16'd0, 16'(dig_obs));
    check_val(name, "ctrl after clear", 16'd0, rd_data);
    finish_test(name);
  endtask

  // ==================================================
  // Main sequence and watchdog
  // ==================================================
  initial begin
    clk          = 1'b0;
    lcg_state    = 32'd42;
    tbl_ready    = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    test_errs    = 0;
    rst_n      <= 1'b0;
    wr_en      <= 1'b0;
    wr_addr    <= '0;
    wr_data    <= '0;
    rd_addr    <= '0;
    io_dbg     <= '0;
    tx_dll_dbg <= 1'b0;
    rx_dll_dbg <= 1'b0;
    dcs_dbg    <= 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    run_reset_test();
    for (int i = 0; i < t_name.size(); i++) begin
      apply_entry(i);
    end
    run_exclusive_test();
    $display("Tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    int limit_cycles;
    wait (tbl_ready);
    limit_cycles = RESET_CYCLES + (t_name.size() + EXTRA_TESTS) * CYCLES_PER_TEST;
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", limit_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- flist.f
rtl/aib_dfx_pkg.sv
rtl/aib_dfx_csr.sv
rtl/aib_dfx_mon.sv
rtl/aib_dfx_obs_mux.sv
rtl/aib_dfx_top.sv
tests/tb_aib_dfx.sv

//--- run.sh
#!/bin/sh
# Compile and run the DFx monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_aib_dfx \
  --Mdir "$OBJ_DIR" -o sim_tb \
  -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
exit 0
